/* tb.f */
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu.sv
dv/cpu_assert.sv
dv/cpu_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module cpu_tb -f tb.f -Mdir obj_dir -o cpu_tb

run: build
	./obj_dir/cpu_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing --assert --top-module cpu_tb -f tb.f

clean:
	rm -rf obj_dir sim.log

/* dv/cpu_tb.sv */
module cpu_tb;

  localparam int prog_words     = 256;
  localparam int init_words     = 64;
  localparam int retire_timeout = 20;
  localparam cpu_pkg::word_t prog_end = 32'h0000_0400;
  localparam cpu_pkg::word_t nop      = 32'h0000_0013;

  logic             clock;
  logic             rst;
  cpu_pkg::word_t   imem_address;
  cpu_pkg::word_t   imem_data;
  cpu_pkg::peri_t   peri_in;
  cpu_pkg::peri_t   peri_out;
  cpu_pkg::retire_t retire;

  cpu_pkg::word_t prog_mem [prog_words];
  logic [31:0]    rng_state;
  cpu_pkg::word_t model_regs [32];
  cpu_pkg::word_t model_ram [cpu_pkg::ram_words];
  cpu_pkg::word_t model_pc;
  cpu_pkg::word_t last_pc;
  cpu_pkg::peri_t model_peri_out;
  cpu_pkg::peri_t peri_prev;
  int             errors;
  int             retired;

  cpu i_dut (
    .clock        (clock),
    .rst          (rst),
    .imem_address (imem_address),
    .imem_data    (imem_data),
    .peri_in      (peri_in),
    .peri_out     (peri_out),
    .retire       (retire)
  );

  // instruction memory, nops past the end
  assign imem_data = (imem_address < prog_end) ? prog_mem[imem_address[9:2]] : nop;

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic cpu_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                            logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::opcode_op};
  endfunction

  function automatic cpu_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                            logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic cpu_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::opcode_store};
  endfunction

  function automatic cpu_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                            logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::opcode_branch};
  endfunction

  function automatic cpu_pkg::word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic cpu_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::opcode_jal};
  endfunction

  // shift immediates keep a legal funct7
  function automatic logic [11:0] shift_safe_imm(logic [2:0] f3, logic [11:0] raw);
    if (f3 == 3'b001) begin
      return {7'b0, raw[4:0]};
    end
    if (f3 == 3'b101) begin
      return {1'b0, raw[10], 5'b0, raw[4:0]};
    end
    return raw;
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] ram_addr;
    logic        peri_hit;
    int          skip;
    for (int i = 0; i < prog_words; i++) begin
      r        = next_random();
      rd       = {2'b00, r[2:0]};
      rs1      = {2'b00, r[5:3]};
      rs2      = {2'b00, r[8:6]};
      f3       = r[11:9];
      skip     = 4 * (1 + int'(r[14:12]));
      ram_addr = {4'b0000, r[20:15], 2'b00};
      peri_hit = r[23:21] == 3'd0;
      if (i < init_words) begin
        // clear the data ram so no load sees an unknown word
        prog_mem[i] = s_type(12'(4 * i), 5'd0, 5'd0);
      end else begin
        case (r[31:28])
          4'd0, 4'd1, 4'd2, 4'd3: begin
            prog_mem[i] = i_type(shift_safe_imm(f3, r[27:16]), rs1, f3, rd,
                                 cpu_pkg::opcode_op_imm);
          end
          4'd4, 4'd5, 4'd6: begin
            prog_mem[i] = r_type(((f3 == 3'b000 || f3 == 3'b101) && r[27]) ? 7'b0100000 : 7'b0,
                                 rs2, rs1, f3, rd);
          end
          4'd7:  prog_mem[i] = u_type(r[27:8], rd, cpu_pkg::opcode_lui);
          4'd8:  prog_mem[i] = u_type(r[27:8], rd, cpu_pkg::opcode_auipc);
          4'd9: begin
            prog_mem[i] = i_type(peri_hit ? cpu_pkg::peri_in_addr[11:0] : ram_addr, 5'd0,
                                 3'b010, rd, cpu_pkg::opcode_load);
          end
          4'd10: prog_mem[i] = s_type(peri_hit ? cpu_pkg::peri_out_addr[11:0] : ram_addr,
                                      rs2, 5'd0);
          4'd11, 4'd12: begin
            // funct3 010 and 011 are not branches
            prog_mem[i] = b_type(13'(skip), rs2, rs1,
                                 (f3[2:1] == 2'b01) ? {2'b00, f3[0]} : f3);
          end
          4'd13: prog_mem[i] = j_type(21'(skip), rd);
          4'd14: prog_mem[i] = i_type(12'(4 * i + skip), 5'd0, 3'b000, rd,
                                      cpu_pkg::opcode_jalr);
          default: prog_mem[i] = i_type(r[27:16], rs1, 3'b000, rd, cpu_pkg::opcode_op_imm);
        endcase
      end
    end
  endtask

  function automatic cpu_pkg::word_t alu_model(logic [2:0] f3, logic alt,
                                               cpu_pkg::word_t a, cpu_pkg::word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? cpu_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_holds(logic [2:0] f3, cpu_pkg::word_t a, cpu_pkg::word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < cpu_pkg::ram_words; i++) begin
      model_ram[i] = '0;
    end
    model_pc       = '0;
    model_peri_out = '0;
  endtask

  // one instruction of the reference model, in program order
  task automatic model_step(output cpu_pkg::retire_t expected, output logic is_store);
    cpu_pkg::word_t instr;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t imm_s;
    cpu_pkg::word_t imm_b;
    cpu_pkg::word_t imm_j;
    cpu_pkg::word_t imm_u;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t next_pc;
    logic [2:0]     f3;
    instr    = (model_pc < prog_end) ? prog_mem[model_pc[9:2]] : nop;
    f3       = instr[14:12];
    a        = model_regs[instr[19:15]];
    b        = model_regs[instr[24:20]];
    imm_i    = {{20{instr[31]}}, instr[31:20]};
    imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_u    = {instr[31:12], 12'b0};
    expected = '0;
    expected.valid = 1'b1;
    expected.rd    = instr[11:7];
    next_pc  = model_pc + 32'd4;
    is_store = 1'b0;
    last_pc  = model_pc;
    case (instr[6:0])
      cpu_pkg::opcode_op_imm: begin
        expected.reg_write = 1'b1;
        expected.data      = alu_model(f3, f3 == 3'b101 && instr[30], a, imm_i);
      end
      cpu_pkg::opcode_op: begin
        expected.reg_write = 1'b1;
        expected.data      = alu_model(f3, instr[30], a, b);
      end
      cpu_pkg::opcode_lui: begin
        expected.reg_write = 1'b1;
        expected.data      = imm_u;
      end
      cpu_pkg::opcode_auipc: begin
        expected.reg_write = 1'b1;
        expected.data      = model_pc + imm_u;
      end
      cpu_pkg::opcode_jal: begin
        expected.reg_write = 1'b1;
        expected.data      = model_pc + 32'd4;
        next_pc            = model_pc + imm_j;
      end
      cpu_pkg::opcode_jalr: begin
        expected.reg_write = 1'b1;
        expected.data      = model_pc + 32'd4;
        next_pc            = (a + imm_i) & ~32'd1;
      end
      cpu_pkg::opcode_branch: begin
        if (branch_holds(f3, a, b)) begin
          next_pc = model_pc + imm_b;
        end
      end
      cpu_pkg::opcode_load: begin
        addr               = a + imm_i;
        expected.reg_write = 1'b1;
        // the load reads peri_in one cycle before it retires
        expected.data      = (addr == cpu_pkg::peri_in_addr) ? {28'b0, peri_prev} :
                             model_ram[addr[7:2]];
      end
      cpu_pkg::opcode_store: begin
        addr     = a + imm_s;
        is_store = 1'b1;
        if (addr == cpu_pkg::peri_out_addr) begin
          model_peri_out = b[3:0];
        end else begin
          model_ram[addr[7:2]] = b;
        end
      end
      default: begin
      end
    endcase
    if (expected.reg_write && expected.rd != 5'd0) begin
      model_regs[expected.rd] = expected.data;
    end
    model_pc = next_pc;
  endtask

  task automatic wait_retire(output logic timed_out);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!retire.valid && cycles < retire_timeout) begin
      @(negedge clock);
      cycles++;
    end
    timed_out = !retire.valid;
  endtask

  task automatic check_retire();
    cpu_pkg::retire_t expected;
    logic             is_store;
    model_step(expected, is_store);
    assert (retire.reg_write == expected.reg_write) else begin
      errors++;
      $display("FAILED retire.reg_write at pc %h: got %h, expected %h",
               last_pc, retire.reg_write, expected.reg_write);
    end
    if (expected.reg_write) begin
      assert (retire.rd == expected.rd) else begin
        errors++;
        $display("FAILED retire.rd at pc %h: got %h, expected %h",
                 last_pc, retire.rd, expected.rd);
      end
      assert (retire.data == expected.data) else begin
        errors++;
        $display("FAILED retire.data at pc %h: got %h, expected %h",
                 last_pc, retire.data, expected.data);
      end
    end
    if (is_store) begin
      assert (peri_out == model_peri_out) else begin
        errors++;
        $display("FAILED peri_out at pc %h: got %h, expected %h",
                 last_pc, peri_out, model_peri_out);
      end
    end
    retired++;
  endtask

  // peri_in as held during the previous cycle
  always @(negedge clock) begin
    peri_prev <= peri_in;
  end

  initial begin
    logic [31:0] r;
    peri_in = '0;
    forever begin
      repeat (16) @(posedge clock);
      #2;
      r       = next_random();
      peri_in = r[3:0];
    end
  end

  initial begin
    logic timed_out;
    rst       = 1'b1;
    errors    = 0;
    retired   = 0;
    timed_out = 1'b0;
    rng_state = 32'd44;
    build_program();
    reset_model();
    repeat (2) @(posedge clock);
    #2;
    rst = 1'b0;
    while (!timed_out && model_pc < prog_end) begin
      wait_retire(timed_out);
      if (!timed_out) begin
        check_retire();
      end
    end
    if (timed_out) begin
      $display("no instruction retired within %0d cycles", retire_timeout);
    end
    $display("errors: %0d, instructions retired: %0d", errors, retired);
    if (errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/cpu_assert.sv */
module cpu_assert (
  input logic clock,
  input logic rst,
  input logic flush,
  input logic ex_valid,
  input logic retire_valid
);

  logic [2:0] since_reset;

  always_ff @(posedge clock) begin
    if (rst) begin
      since_reset <= '0;
    end else if (since_reset != 3'd7) begin
      since_reset <= since_reset + 3'd1;
    end
  end

  flush_single: assert property (@(posedge clock) disable iff (rst) flush |=> !flush)
    else $error("flush held for more than one cycle");

  // pipeline is still filling
  no_early_retire: assert property (@(posedge clock) disable iff (rst)
    since_reset < 3'd4 |-> !retire_valid)
    else $error("retirement within four cycles of reset");

  flush_clears_ex: assert property (@(posedge clock) disable iff (rst) flush |=> !ex_valid)
    else $error("execute stage valid in the cycle after a flush");

endmodule

bind execute_stage cpu_assert i_execute_assert (
  .clock        (clock),
  .rst          (rst),
  .flush        (flush),
  .ex_valid     (ex.valid),
  .retire_valid (1'b0)
);

bind memory_stage cpu_assert i_memory_assert (
  .clock        (clock),
  .rst          (rst),
  .flush        (1'b0),
  .ex_valid     (1'b0),
  .retire_valid (wb.valid)
);

/* rtl/cpu.sv */
module cpu (
  input  logic             clock,
  input  logic             rst,
  output cpu_pkg::word_t   imem_address,
  input  cpu_pkg::word_t   imem_data,
  input  cpu_pkg::peri_t   peri_in,
  output cpu_pkg::peri_t   peri_out,
  output cpu_pkg::retire_t retire
);

  cpu_pkg::fetch_t     fetch;
  cpu_pkg::reg_index_t rs1;
  cpu_pkg::reg_index_t rs2;
  cpu_pkg::word_t      rs1_data;
  cpu_pkg::word_t      rs2_data;
  cpu_pkg::decode_t    decoded_fields;
  cpu_pkg::decode_t    decoded;
  cpu_pkg::exec_t      exec;
  cpu_pkg::exec_t      mem_fwd;
  cpu_pkg::retire_t    wb;
  logic                flush;
  cpu_pkg::word_t      target;

  fetch_stage i_fetch (
    .clock        (clock),
    .rst          (rst),
    .flush        (flush),
    .target       (target),
    .imem_address (imem_address),
    .imem_data    (imem_data),
    .fetch        (fetch)
  );

  decoder i_decoder (
    .fetch   (fetch),
    .rs1     (rs1),
    .rs2     (rs2),
    .decoded (decoded_fields)
  );

  register_file i_register_file (
    .clock    (clock),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // read data joins the decoded fields
  always_comb begin
    decoded          = decoded_fields;
    decoded.rs1_data = rs1_data;
    decoded.rs2_data = rs2_data;
  end

  execute_stage i_execute (
    .clock   (clock),
    .rst     (rst),
    .decoded (decoded),
    .mem_fwd (mem_fwd),
    .wb      (wb),
    .exec    (exec),
    .flush   (flush),
    .target  (target)
  );

  memory_stage i_memory (
    .clock    (clock),
    .rst      (rst),
    .exec_in  (exec),
    .peri_in  (peri_in),
    .peri_out (peri_out),
    .mem_fwd  (mem_fwd),
    .wb       (wb)
  );

  assign retire = wb;

endmodule

/* rtl/memory_stage.sv */
module memory_stage (
  input  logic             clock,
  input  logic             rst,
  input  cpu_pkg::exec_t   exec_in,
  input  cpu_pkg::peri_t   peri_in,
  output cpu_pkg::peri_t   peri_out,
  output cpu_pkg::exec_t   mem_fwd,
  output cpu_pkg::retire_t wb
);

  cpu_pkg::exec_t mem;
  cpu_pkg::word_t ram [cpu_pkg::ram_words];
  logic [cpu_pkg::ram_addr_bits-1:0] ram_index;
  cpu_pkg::word_t load_data;
  logic store_en;
  logic peri_out_hit;

  always_ff @(posedge clock) begin
    mem <= exec_in;
    if (rst) begin
      mem.valid <= 1'b0;
    end
  end

  // word index, wraps within the ram
  assign ram_index    = mem.result[2 +: cpu_pkg::ram_addr_bits];
  assign store_en     = mem.valid && mem.mem_write;
  assign peri_out_hit = mem.result == cpu_pkg::peri_out_addr;

  always_ff @(posedge clock) begin
    if (store_en && !peri_out_hit) begin
      ram[ram_index] <= mem.store_data;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      peri_out <= '0;
    end else if (store_en && peri_out_hit) begin
      peri_out <= mem.store_data[3:0];
    end
  end

  assign load_data = (mem.result == cpu_pkg::peri_in_addr) ?
                     cpu_pkg::word_t'(peri_in) : ram[ram_index];

  // load data already in result, so execute can forward it
  always_comb begin
    mem_fwd        = mem;
    mem_fwd.result = mem.mem_read ? load_data : mem.result;
  end

  always_ff @(posedge clock) begin
    wb.valid     <= mem_fwd.valid;
    wb.rd        <= mem_fwd.rd;
    wb.data      <= mem_fwd.result;
    wb.reg_write <= mem_fwd.reg_write;
    if (rst) begin
      wb.valid <= 1'b0;
    end
  end

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
  input  logic             clock,
  input  logic             rst,
  input  cpu_pkg::decode_t decoded,
  input  cpu_pkg::exec_t   mem_fwd,
  input  cpu_pkg::retire_t wb,
  output cpu_pkg::exec_t   exec,
  output logic             flush,
  output cpu_pkg::word_t   target
);

  cpu_pkg::decode_t ex;
  cpu_pkg::word_t rs1_value;
  cpu_pkg::word_t rs2_value;
  cpu_pkg::word_t alu_a;
  cpu_pkg::word_t alu_b;
  cpu_pkg::word_t alu_result;
  cpu_pkg::word_t link;
  logic is_jump;
  logic taken;

  always_ff @(posedge clock) begin
    ex <= decoded;
    if (rst || flush) begin
      ex.valid <= 1'b0;
    end
  end

  // memory stage first, then writeback, then register value
  function automatic cpu_pkg::word_t forward(cpu_pkg::reg_index_t idx,
                                             cpu_pkg::word_t reg_value,
                                             cpu_pkg::exec_t m,
                                             cpu_pkg::retire_t w);
    if (idx == '0) begin
      return reg_value;
    end else if (m.valid && m.reg_write && m.rd == idx) begin
      return m.result;
    end else if (w.valid && w.reg_write && w.rd == idx) begin
      return w.data;
    end
    return reg_value;
  endfunction

  assign rs1_value = forward(ex.rs1, ex.rs1_data, mem_fwd, wb);
  assign rs2_value = forward(ex.rs2, ex.rs2_data, mem_fwd, wb);

  assign alu_a = ex.use_pc ? ex.pc : rs1_value;
  assign alu_b = ex.use_rs2 ? rs2_value : ex.immediate;

  always_comb begin
    case (ex.alu_op)
      cpu_pkg::alu_add:  alu_result = alu_a + alu_b;
      cpu_pkg::alu_sub:  alu_result = alu_a - alu_b;
      cpu_pkg::alu_sll:  alu_result = alu_a << alu_b[4:0];
      cpu_pkg::alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      cpu_pkg::alu_sltu: alu_result = {31'b0, alu_a < alu_b};
      cpu_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
      cpu_pkg::alu_srl:  alu_result = alu_a >> alu_b[4:0];
      cpu_pkg::alu_sra:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
      cpu_pkg::alu_or:   alu_result = alu_a | alu_b;
      cpu_pkg::alu_and:  alu_result = alu_a & alu_b;
      default:           alu_result = alu_b;
    endcase
  end

  assign is_jump = ex.branch_kind == cpu_pkg::branch_jal ||
                   ex.branch_kind == cpu_pkg::branch_jalr;
  assign link    = ex.pc + 32'd4;

  always_comb begin
    case (ex.branch_kind)
      cpu_pkg::branch_eq:  taken = rs1_value == rs2_value;
      cpu_pkg::branch_ne:  taken = rs1_value != rs2_value;
      cpu_pkg::branch_lt:  taken = $signed(rs1_value) < $signed(rs2_value);
      cpu_pkg::branch_ge:  taken = $signed(rs1_value) >= $signed(rs2_value);
      cpu_pkg::branch_ltu: taken = rs1_value < rs2_value;
      cpu_pkg::branch_geu: taken = rs1_value >= rs2_value;
      default:             taken = is_jump;
    endcase
  end

  assign flush  = ex.valid && taken;
  // jalr target drops bit 0
  assign target = (ex.branch_kind == cpu_pkg::branch_jalr) ?
                  ((rs1_value + ex.immediate) & ~32'd1) : ex.pc + ex.immediate;

  always_comb begin
    exec.valid      = ex.valid;
    exec.rd         = ex.rd;
    exec.result     = is_jump ? link : alu_result;
    exec.store_data = rs2_value;
    exec.reg_write  = ex.reg_write;
    exec.mem_read   = ex.mem_read;
    exec.mem_write  = ex.mem_write;
  end

endmodule

/* rtl/register_file.sv */
module register_file (
  input  logic                clock,
  input  logic                rst,
  input  cpu_pkg::reg_index_t rs1,
  input  cpu_pkg::reg_index_t rs2,
  output cpu_pkg::word_t      rs1_data,
  output cpu_pkg::word_t      rs2_data,
  input  cpu_pkg::retire_t    wb
);

  cpu_pkg::word_t regs [32];
  logic write_en;

  assign write_en = wb.valid && wb.reg_write && wb.rd != '0;

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 reads zero, same-cycle write is bypassed
  assign rs1_data = (rs1 == '0) ? '0 : (write_en && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (write_en && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

/* rtl/decoder.sv */
module decoder (
  input  cpu_pkg::fetch_t     fetch,
  output cpu_pkg::reg_index_t rs1,
  output cpu_pkg::reg_index_t rs2,
  output cpu_pkg::decode_t    decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  cpu_pkg::word_t imm_i;
  cpu_pkg::word_t imm_s;
  cpu_pkg::word_t imm_b;
  cpu_pkg::word_t imm_u;
  cpu_pkg::word_t imm_j;

  assign opcode = fetch.instruction[6:0];
  assign funct3 = fetch.instruction[14:12];
  assign funct7 = fetch.instruction[31:25];
  assign rs1    = fetch.instruction[19:15];
  assign rs2    = fetch.instruction[24:20];

  assign imm_i = {{20{fetch.instruction[31]}}, fetch.instruction[31:20]};
  assign imm_s = {{20{fetch.instruction[31]}}, fetch.instruction[31:25],
                  fetch.instruction[11:7]};
  assign imm_b = {{19{fetch.instruction[31]}}, fetch.instruction[31], fetch.instruction[7],
                  fetch.instruction[30:25], fetch.instruction[11:8], 1'b0};
  assign imm_u = {fetch.instruction[31:12], 12'b0};
  assign imm_j = {{11{fetch.instruction[31]}}, fetch.instruction[31],
                  fetch.instruction[19:12], fetch.instruction[20],
                  fetch.instruction[30:21], 1'b0};

  // funct3 to alu op, alt selects sub or sra
  function automatic cpu_pkg::alu_op_t alu_of(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
      3'b001:  return cpu_pkg::alu_sll;
      3'b010:  return cpu_pkg::alu_slt;
      3'b011:  return cpu_pkg::alu_sltu;
      3'b100:  return cpu_pkg::alu_xor;
      3'b101:  return alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
      3'b110:  return cpu_pkg::alu_or;
      default: return cpu_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    decoded             = '0;
    decoded.valid       = fetch.valid;
    decoded.pc          = fetch.pc;
    decoded.rs1         = rs1;
    decoded.rs2         = rs2;
    decoded.rd          = fetch.instruction[11:7];
    decoded.alu_op      = cpu_pkg::alu_add;
    decoded.branch_kind = cpu_pkg::branch_none;
    case (opcode)
      cpu_pkg::opcode_op_imm: begin
        decoded.immediate = imm_i;
        decoded.alu_op    = alu_of(funct3, funct3 == 3'b101 && funct7[5]);
        // shift amounts need a clean funct7
        if (funct3 == 3'b001) begin
          decoded.reg_write = funct7 == 7'b0000000;
        end else if (funct3 == 3'b101) begin
          decoded.reg_write = funct7 == 7'b0000000 || funct7 == 7'b0100000;
        end else begin
          decoded.reg_write = 1'b1;
        end
      end
      cpu_pkg::opcode_op: begin
        decoded.use_rs2   = 1'b1;
        decoded.alu_op    = alu_of(funct3, funct7[5]);
        decoded.reg_write = funct7 == 7'b0000000 ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      cpu_pkg::opcode_lui: begin
        decoded.immediate = imm_u;
        decoded.alu_op    = cpu_pkg::alu_copy_b;
        decoded.reg_write = 1'b1;
      end
      cpu_pkg::opcode_auipc: begin
        decoded.immediate = imm_u;
        decoded.use_pc    = 1'b1;
        decoded.reg_write = 1'b1;
      end
      cpu_pkg::opcode_jal: begin
        decoded.immediate   = imm_j;
        decoded.reg_write   = 1'b1;
        decoded.branch_kind = cpu_pkg::branch_jal;
      end
      cpu_pkg::opcode_jalr: begin
        decoded.immediate = imm_i;
        if (funct3 == 3'b000) begin
          decoded.reg_write   = 1'b1;
          decoded.branch_kind = cpu_pkg::branch_jalr;
        end
      end
      cpu_pkg::opcode_branch: begin
        decoded.immediate = imm_b;
        case (funct3)
          3'b000:  decoded.branch_kind = cpu_pkg::branch_eq;
          3'b001:  decoded.branch_kind = cpu_pkg::branch_ne;
          3'b100:  decoded.branch_kind = cpu_pkg::branch_lt;
          3'b101:  decoded.branch_kind = cpu_pkg::branch_ge;
          3'b110:  decoded.branch_kind = cpu_pkg::branch_ltu;
          3'b111:  decoded.branch_kind = cpu_pkg::branch_geu;
          default: decoded.branch_kind = cpu_pkg::branch_none;
        endcase
      end
      cpu_pkg::opcode_load: begin
        decoded.immediate = imm_i;
        // word accesses only
        decoded.mem_read  = funct3 == 3'b010;
        decoded.reg_write = funct3 == 3'b010;
      end
      cpu_pkg::opcode_store: begin
        decoded.immediate = imm_s;
        decoded.mem_write = funct3 == 3'b010;
      end
      default: begin
        decoded.reg_write = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/fetch_stage.sv */
module fetch_stage (
  input  logic            clock,
  input  logic            rst,
  input  logic            flush,
  input  cpu_pkg::word_t  target,
  output cpu_pkg::word_t  imem_address,
  input  cpu_pkg::word_t  imem_data,
  output cpu_pkg::fetch_t fetch
);

  cpu_pkg::word_t pc;

  assign imem_address = pc;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= '0;
    end else if (flush) begin
      pc <= target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // fetch-to-decode register, only valid is cleared
  always_ff @(posedge clock) begin
    fetch.valid       <= 1'b1;
    fetch.pc          <= pc;
    fetch.instruction <= imem_data;
    if (rst || flush) begin
      fetch.valid <= 1'b0;
    end
  end

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_index_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [3:0]  branch_kind_t;
  typedef logic [3:0]  peri_t;

  // alu operation codes
  localparam alu_op_t alu_add    = 4'd0;
  localparam alu_op_t alu_sub    = 4'd1;
  localparam alu_op_t alu_sll    = 4'd2;
  localparam alu_op_t alu_slt    = 4'd3;
  localparam alu_op_t alu_sltu   = 4'd4;
  localparam alu_op_t alu_xor    = 4'd5;
  localparam alu_op_t alu_srl    = 4'd6;
  localparam alu_op_t alu_sra    = 4'd7;
  localparam alu_op_t alu_or     = 4'd8;
  localparam alu_op_t alu_and    = 4'd9;
  localparam alu_op_t alu_copy_b = 4'd10;

  // branch kinds, resolved in execute
  localparam branch_kind_t branch_none = 4'd0;
  localparam branch_kind_t branch_eq   = 4'd1;
  localparam branch_kind_t branch_ne   = 4'd2;
  localparam branch_kind_t branch_lt   = 4'd3;
  localparam branch_kind_t branch_ge   = 4'd4;
  localparam branch_kind_t branch_ltu  = 4'd5;
  localparam branch_kind_t branch_geu  = 4'd6;
  localparam branch_kind_t branch_jal  = 4'd7;
  // shares no code with the others, so the width needs a fourth bit
  localparam branch_kind_t branch_jalr = 4'd8;

  // rv32i major opcodes
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;

  // data address map
  localparam int    ram_words     = 64;
  localparam int    ram_addr_bits = $clog2(ram_words);
  localparam word_t peri_out_addr = 32'h0000_0100;
  localparam word_t peri_in_addr  = 32'h0000_0104;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instruction;
  } fetch_t;

  typedef struct packed {
    logic         valid;
    word_t        pc;
    reg_index_t   rs1;
    reg_index_t   rs2;
    word_t        rs1_data;
    word_t        rs2_data;
    reg_index_t   rd;
    word_t        immediate;
    logic         use_rs2;
    alu_op_t      alu_op;
    logic         use_pc;
    logic         reg_write;
    logic         mem_read;
    logic         mem_write;
    branch_kind_t branch_kind;
  } decode_t;

  typedef struct packed {
    logic       valid;
    reg_index_t rd;
    word_t      result;
    word_t      store_data;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
  } exec_t;

  typedef struct packed {
    logic       valid;
    reg_index_t rd;
    word_t      data;
    logic       reg_write;
  } retire_t;

endpackage
